//--- src/board_pkg.sv
package board_pkg;

    //----------------------------------------
    // panel geometry
    //----------------------------------------

    // width of one hex digit
    localparam int w_nibble = 4;

    // digits, leds and keys on the panel
    localparam int n_panel = 8;

    typedef logic [w_nibble - 1:0] nibble_t;

    // abcdefgh order, bit 7 is segment a and bit 0 the dot
    typedef logic [7:0] segs_t;

endpackage

//--- src/tm1638_pkg.sv
package tm1638_pkg;

    // top two bits of every command byte
    typedef enum logic [1:0] {
        cls_data    = 2'b01,
        cls_display = 2'b10,
        cls_address = 2'b11
    } cmd_class_t;

    typedef struct packed {
        cmd_class_t cls;
        logic [1:0] rsvd;
        logic       test_mode;
        logic       fixed_addr;
        logic       read_keys;
        logic       rsvd_lo;
    } data_view_t;

    typedef struct packed {
        cmd_class_t cls;
        logic [1:0] rsvd;
        logic [3:0] addr;
    } addr_view_t;

    typedef union packed {
        data_view_t data;
        addr_view_t addr;
    } tm1638_cmd_u;

    // low nibble of display control, on bit plus brightness 7
    localparam logic [3:0] display_on_full = 4'hf;

    localparam int n_key_bytes  = 4;
    localparam int n_grid_bytes = 16;

endpackage

//--- src/display_if.sv
`timescale 1ns/1ps

// steady display content, no handshake
interface display_if;

    // one nibble per digit, digit 0 is the least significant
    board_pkg::nibble_t [board_pkg::n_panel - 1:0] hex;

    // 1 means the digit stays dark
    logic [board_pkg::n_panel - 1:0] blank;

    logic [board_pkg::n_panel - 1:0] dots;
    logic [board_pkg::n_panel - 1:0] led;

    modport source
    (
        output hex,
        output blank,
        output dots,
        output led
    );

    modport sink
    (
        input hex,
        input blank,
        input dots,
        input led
    );

endinterface

//--- src/key_conditioner.sv
`timescale 1ns/1ps

module key_conditioner
#(
    parameter w_key = 2
)
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic [w_key - 1:0]              key,
    input  logic [board_pkg::n_panel - 1:0] panel_keys,
    output logic                            press_run,
    output logic                            press_clear
);

    logic [w_key - 1:0] key_meta;
    logic [w_key - 1:0] key_sync;
    logic [1:0]         panel_d1;
    logic [1:0]         panel_d2;
    logic [1:0]         merged;
    logic [1:0]         merged_prev;

    //----------------------------------------
    // synchronizer and matching panel delay
    //----------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            key_meta <= '0;
            key_sync <= '0;
            panel_d1 <= '0;
            panel_d2 <= '0;
        end
        else
        begin
            // board keys are active low
            key_meta <= ~key;
            key_sync <= key_meta;
            // panel keys take the same two stages
            panel_d1 <= panel_keys[1:0];
            panel_d2 <= panel_d1;
        end
    end

    // key 0 is run/stop, key 1 is clear
    assign merged = key_sync[1:0] | panel_d2;

    //----------------------------------------
    // rising edge strobes
    //----------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            merged_prev <= '0;
            press_run   <= 1'b0;
            press_clear <= 1'b0;
        end
        else
        begin
            merged_prev <= merged;
            press_run   <= merged[0] & ~merged_prev[0];
            press_clear <= merged[1] & ~merged_prev[1];
        end
    end

    // a change on key 0 alone never fires clear
    // key 1 steady in both delay lines, two strobe stages later
    assert property (@(posedge clk) disable iff (rst)
        (key_meta[1] == key_sync[1] && panel_d1[1] == panel_d2[1])
        |-> ##2 !(press_run && press_clear));

endmodule

//--- src/hex_counter.sv
`timescale 1ns/1ps

module hex_counter
#(
    parameter tick_div = 6_750_000
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      press_run,
    input  logic      press_clear,
    display_if.source disp
);

    localparam int w_div   = tick_div > 1 ? $clog2(tick_div) : 1;
    localparam int w_count = board_pkg::n_panel * board_pkg::w_nibble;

    logic [w_div - 1:0]   div_cnt;
    logic                 tick;
    logic                 running;
    logic [w_count - 1:0] count;

    //----------------------------------------
    // prescaler
    //----------------------------------------

    // one tick every tick_div cycles from reset release
    assign tick = (div_cnt == w_div'(tick_div - 1));

    always_ff @(posedge clk)
    begin
        if (rst || tick)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // run flag and count, clear wins over tick
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            running <= 1'b0;
            count   <= '0;
        end
        else
        begin
            if (press_run)
                running <= !running;
            if (press_clear)
                count <= '0;
            else if (tick && running)
                count <= count + 1'b1;
        end
    end

    //----------------------------------------
    // display content
    //----------------------------------------

    always_comb
    begin : blanking
        board_pkg::nibble_t nib;
        logic               seen;
        seen = 1'b0;
        // walk down from the top digit, digit 0 always lit
        for (int i = board_pkg::n_panel - 1; i >= 0; i--)
        begin
            nib = count[i * board_pkg::w_nibble +: board_pkg::w_nibble];
            disp.hex[i] = nib;
            seen = seen || (nib != '0) || (i == 0);
            disp.blank[i] = !seen;
        end
    end

    // dot on digit 0 while running
    assign disp.dots = {{(board_pkg::n_panel - 1){1'b0}}, running};
    assign disp.led  = count[board_pkg::n_panel - 1:0];

    assert property (@(posedge clk) disable iff (rst)
        !(tick || press_clear) |=> $stable(count));

endmodule

//--- src/tm1638_board_controller.sv
`timescale 1ns/1ps

module tm1638_board_controller
#(
    parameter clk_mhz = 27,
    // half period of sio_clk in clk cycles, at least 2
    parameter sio_div = 14
)
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            sio_data_in,
    display_if.sink                         disp,
    output logic [board_pkg::n_panel - 1:0] panel_keys,
    output logic                            sio_clk,
    output logic                            sio_stb,
    output logic                            sio_data_out,
    output logic                            sio_data_oe
);

    // stb high for about 1 us between commands
    localparam int gap_cycles = clk_mhz;
    localparam int tmr_max    = gap_cycles > sio_div ? gap_cycles : sio_div;
    localparam int w_tmr      = $clog2(tmr_max + 1);
    localparam int w_key_sr   = 8 * tm1638_pkg::n_key_bytes;

    typedef enum logic [1:0] {st_gap, st_lo, st_hi} state_t;

    state_t                                        state;
    logic [w_tmr - 1:0]                            tmr;
    logic [1:0]                                    cmd_idx;
    logic [4:0]                                    byte_idx;
    logic [2:0]                                    bit_idx;
    logic [4:0]                                    last_byte;
    logic                                          reading;
    logic [7:0]                                    cur_byte;
    logic [w_key_sr - 1:0]                         key_sr;
    logic [board_pkg::n_panel - 1:0]               key_map;
    board_pkg::nibble_t [board_pkg::n_panel - 1:0] snap_hex;
    logic [board_pkg::n_panel - 1:0]               snap_blank;
    logic [board_pkg::n_panel - 1:0]               snap_dots;
    logic [board_pkg::n_panel - 1:0]               snap_led;

    function automatic board_pkg::segs_t seg_encode(board_pkg::nibble_t h, logic dark,
                                                    logic dot);
        board_pkg::segs_t s;
        case (h)
            4'h0: s = 8'b1111_1100;
            4'h1: s = 8'b0110_0000;
            4'h2: s = 8'b1101_1010;
            4'h3: s = 8'b1111_0010;
            4'h4: s = 8'b0110_0110;
            4'h5: s = 8'b1011_0110;
            4'h6: s = 8'b1011_1110;
            4'h7: s = 8'b1110_0000;
            4'h8: s = 8'b1111_1110;
            4'h9: s = 8'b1111_0110;
            4'ha: s = 8'b1110_1110;
            4'hb: s = 8'b0011_1110;
            4'hc: s = 8'b1001_1100;
            4'hd: s = 8'b0111_1010;
            4'he: s = 8'b1001_1110;
            default: s = 8'b1000_1110;
        endcase
        if (dark)
            s = '0;
        s[0] = dot;
        return s;
    endfunction

    // the chip wants segment a in bit 0
    function automatic logic [7:0] to_hgfedcba(board_pkg::segs_t s);
        logic [7:0] r;
        for (int i = 0; i < 8; i++)
            r[i] = s[7 - i];
        return r;
    endfunction

    //----------------------------------------
    // byte on the wire for cmd_idx/byte_idx
    //----------------------------------------

    always_comb
    begin : byte_select
        tm1638_pkg::tm1638_cmd_u cmd;
        logic [3:0]              grid;
        logic [2:0]              digit;
        cmd      = '0;
        cur_byte = 8'hff;
        grid     = 4'(byte_idx - 5'd1);
        // grid pair 0 is the leftmost digit, which holds the top nibble
        digit    = ~grid[3:1];
        case (cmd_idx)
            2'd0:
            begin
                // write with auto increment
                cmd.data.cls = tm1638_pkg::cls_data;
                cur_byte     = cmd;
            end
            2'd1:
            begin
                cmd.addr.cls = tm1638_pkg::cls_address;
                if (byte_idx == 5'd0)
                    cur_byte = cmd;
                else if (!grid[0])
                    cur_byte = to_hgfedcba(seg_encode(snap_hex[digit], snap_blank[digit],
                                                      snap_dots[digit]));
                else
                    cur_byte = {7'b0, snap_led[digit]};
            end
            2'd2:
            begin
                cmd.data.cls       = tm1638_pkg::cls_data;
                cmd.data.read_keys = 1'b1;
                if (byte_idx == 5'd0)
                    cur_byte = cmd;
            end
            default:
            begin
                cmd.addr.cls  = tm1638_pkg::cls_display;
                cmd.addr.addr = tm1638_pkg::display_on_full;
                cur_byte      = cmd;
            end
        endcase
    end

    always_comb
    begin
        case (cmd_idx)
            2'd1:    last_byte = 5'(tm1638_pkg::n_grid_bytes);
            2'd2:    last_byte = 5'(tm1638_pkg::n_key_bytes);
            default: last_byte = 5'd0;
        endcase
    end

    assign reading = (cmd_idx == 2'd2) && (byte_idx != 5'd0);

    // key k sits in bit (k / 4) * 4 of scan byte k % 4
    always_comb
    begin
        for (int k = 0; k < board_pkg::n_panel; k++)
            key_map[k] = key_sr[8 * (k % 4) + (k / 4) * 4];
    end

    //----------------------------------------
    // frame engine
    //----------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state        <= st_gap;
            tmr          <= w_tmr'(gap_cycles - 1);
            cmd_idx      <= 2'd0;
            byte_idx     <= 5'd0;
            bit_idx      <= 3'd0;
            sio_clk      <= 1'b1;
            sio_stb      <= 1'b1;
            sio_data_out <= 1'b1;
            sio_data_oe  <= 1'b0;
            panel_keys   <= '0;
        end
        else
        begin
            if (tmr != '0)
                tmr <= tmr - 1'b1;
            case (state)
                st_gap:
                    if (tmr == '0)
                    begin
                        sio_stb <= 1'b0;
                        sio_clk <= 1'b0;
                        tmr     <= w_tmr'(sio_div - 1);
                        state   <= st_lo;
                    end
                st_lo:
                begin
                    // data moves one cycle after the falling clock
                    sio_data_out <= cur_byte[bit_idx];
                    sio_data_oe  <= !reading;
                    if (tmr == '0)
                    begin
                        sio_clk <= 1'b1;
                        tmr     <= w_tmr'(sio_div - 1);
                        state   <= st_hi;
                    end
                end
                st_hi:
                    if (tmr == '0)
                    begin
                        if (bit_idx != 3'd7)
                        begin
                            bit_idx <= bit_idx + 3'd1;
                            sio_clk <= 1'b0;
                            tmr     <= w_tmr'(sio_div - 1);
                            state   <= st_lo;
                        end
                        else if (byte_idx != last_byte)
                        begin
                            byte_idx <= byte_idx + 5'd1;
                            bit_idx  <= 3'd0;
                            sio_clk  <= 1'b0;
                            tmr      <= w_tmr'(sio_div - 1);
                            state    <= st_lo;
                        end
                        else
                        begin
                            // command done, release the bus
                            sio_stb     <= 1'b1;
                            sio_data_oe <= 1'b0;
                            byte_idx    <= 5'd0;
                            bit_idx     <= 3'd0;
                            cmd_idx     <= cmd_idx + 2'd1;
                            tmr         <= w_tmr'(gap_cycles - 1);
                            state       <= st_gap;
                            if (cmd_idx == 2'd2)
                                panel_keys <= key_map;
                        end
                    end
                default:
                    state <= st_gap;
            endcase
        end
    end

    // snapshot at frame start and key shift on rising sio_clk
    always_ff @(posedge clk)
    begin
        if (state == st_gap && tmr == '0 && cmd_idx == 2'd0)
        begin
            snap_hex   <= disp.hex;
            snap_blank <= disp.blank;
            snap_dots  <= disp.dots;
            snap_led   <= disp.led;
        end
        if (state == st_lo && tmr == '0 && reading)
            key_sr <= {sio_data_in, key_sr[w_key_sr - 1:1]};
    end

    // dio is driven only inside a framed command
    assert property (@(posedge clk) disable iff (rst) sio_stb |-> !sio_data_oe);

endmodule

//--- src/board_top.sv
`timescale 1ns/1ps

module board_top
#(
    parameter clk_mhz  = 27,
              sio_div  = 14,
              tick_div = 6_750_000,
              w_key    = 2
)
(
    input  logic               clk,
    input  logic               rst,
    input  logic [w_key - 1:0] key,
    input  logic               sio_data_in,
    output logic               sio_clk,
    output logic               sio_stb,
    output logic               sio_data_out,
    output logic               sio_data_oe
);

    logic [board_pkg::n_panel - 1:0] panel_keys;
    logic                            press_run;
    logic                            press_clear;

    display_if disp ();

    //----------------------------------------
    // keys in, counter, panel out
    //----------------------------------------

    key_conditioner #(.w_key (w_key)) i_key_conditioner
    (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .key         ( key         ),
        .panel_keys  ( panel_keys  ),
        .press_run   ( press_run   ),
        .press_clear ( press_clear )
    );

    hex_counter #(.tick_div (tick_div)) i_hex_counter
    (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .press_run   ( press_run   ),
        .press_clear ( press_clear ),
        .disp        ( disp.source )
    );

    tm1638_board_controller #(.clk_mhz (clk_mhz), .sio_div (sio_div)) i_tm1638
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .sio_data_in  ( sio_data_in  ),
        .disp         ( disp.sink    ),
        .panel_keys   ( panel_keys   ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  )
    );

endmodule

//--- tests/tm1638_model.sv
`timescale 1ns/1ps

module tm1638_model
(
    input  logic        sio_clk,
    input  logic        sio_stb,
    input  logic        sio_data_out,
    input  logic        sio_data_oe,
    input  logic [7:0]  key_mask,
    output logic        sio_data_in,
    output logic [31:0] value,
    output logic [7:0]  dark,
    output logic [7:0]  dots,
    output logic [7:0]  leds,
    output logic        bad_seg,
    output logic        oe_bad,
    output int          frames
);

    // gfedcba shapes of the hex digits 0 to f
    localparam logic [6:0] shapes [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    tm1638_pkg::tm1638_cmd_u cmd;
    logic [7:0]              grid [16];
    logic [7:0]              sr;
    logic [3:0]              addr;
    logic                    reading;
    logic                    writing;
    int                      n_bits;
    int                      n_bytes;

    // -1 for a shape that is no hex digit
    function automatic int seg_to_hex(input logic [6:0] s);
        int h;
        h = -1;
        for (int i = 0; i < 16; i++)
            if (shapes[i] == s)
                h = i;
        return h;
    endfunction

    initial
    begin
        sio_data_in = 1'b1;
        value       = '0;
        dark        = '1;
        dots        = '0;
        leds        = '0;
        bad_seg     = 1'b0;
        oe_bad      = 1'b0;
        frames      = 0;
        n_bits      = 0;
        n_bytes     = 0;
        reading     = 1'b0;
        writing     = 1'b0;
    end

    //----------------------------------------
    // command decode, lsb first
    //----------------------------------------

    always @(posedge sio_clk or posedge sio_stb)
    begin : decode
        int         d;
        int         h;
        logic [7:0] s;
        if (sio_stb)
        begin
            // end of a full grid write, publish what the panel shows
            if (writing && n_bytes == 1 + tm1638_pkg::n_grid_bytes)
            begin
                bad_seg = 1'b0;
                for (int p = 0; p < 8; p++)
                begin
                    // leftmost position is the top digit
                    d = 7 - p;
                    s = grid[2 * p];
                    h = seg_to_hex(s[6:0]);
                    dots[d] = s[7];
                    dark[d] = (s[6:0] == 7'h00);
                    leds[d] = grid[2 * p + 1][0];
                    if (dark[d] || h < 0)
                        value[4 * d +: 4] = 4'h0;
                    else
                        value[4 * d +: 4] = h[3:0];
                    if (!dark[d] && h < 0)
                        bad_seg = 1'b1;
                end
                frames++;
            end
            n_bits  = 0;
            n_bytes = 0;
            reading = 1'b0;
            writing = 1'b0;
        end
        else
        begin
            // dio belongs to the panel only in the key bytes of a read
            if (sio_data_oe != !(reading && n_bytes >= 1))
                oe_bad = 1'b1;
            sr = {sio_data_out, sr[7:1]};
            n_bits++;
            if (n_bits == 8)
            begin
                n_bits = 0;
                if (n_bytes == 0)
                begin
                    cmd     = sr;
                    reading = (cmd.data.cls == tm1638_pkg::cls_data) && cmd.data.read_keys;
                    writing = (cmd.addr.cls == tm1638_pkg::cls_address);
                    addr    = cmd.addr.addr;
                end
                else if (writing)
                begin
                    grid[addr] = sr;
                    addr++;
                end
                n_bytes++;
            end
        end
    end

    // key k sits in bit (k / 4) * 4 of scan byte k % 4
    always @(negedge sio_clk)
    begin
        if (!sio_stb && reading && n_bytes >= 1 && n_bytes <= tm1638_pkg::n_key_bytes)
        begin
            if (n_bits == 0)
                sio_data_in = key_mask[n_bytes - 1];
            else if (n_bits == 4)
                sio_data_in = key_mask[n_bytes + 3];
            else
                sio_data_in = 1'b0;
        end
    end

endmodule

//--- tests/board_top_tb.sv
`timescale 1ns/1ps

module board_top_tb;

    localparam int clk_mhz       = 3;
    localparam int sio_div       = 2;
    localparam int tick_div      = 200;
    localparam int frame_timeout = 4000;

    typedef enum logic [1:0] {act_wait, act_board_key, act_panel_key} action_t;
    typedef enum logic [1:0] {exp_zero, exp_running, exp_stopped, exp_cleared} outcome_t;

    typedef struct packed {
        action_t  act;
        int       key_idx;
        outcome_t outcome;
    } step_t;

    //----------------------------------------
    // action table
    //----------------------------------------

    step_t steps [9] = '{
        '{act_wait,      0, exp_zero},
        '{act_board_key, 0, exp_running},
        '{act_wait,      0, exp_running},
        '{act_panel_key, 0, exp_stopped},
        '{act_board_key, 1, exp_cleared},
        '{act_panel_key, 0, exp_running},
        '{act_board_key, 0, exp_stopped},
        '{act_panel_key, 1, exp_cleared},
        '{act_wait,      0, exp_zero}
    };

    logic        clk = 1'b0;
    logic        rst;
    logic [1:0]  key;
    logic [7:0]  key_mask;
    logic        sio_data_in;
    logic        sio_clk;
    logic        sio_stb;
    logic        sio_data_out;
    logic        sio_data_oe;
    logic [31:0] shown;
    logic [7:0]  dark;
    logic [7:0]  dots;
    logic [7:0]  leds;
    logic        bad_seg;
    logic        oe_bad;
    int          frames;
    int          seed = 4830;

    always #2 clk = ~clk;

    board_top #(.clk_mhz (clk_mhz), .sio_div (sio_div), .tick_div (tick_div), .w_key (2)) uut
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .key          ( key          ),
        .sio_data_in  ( sio_data_in  ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  )
    );

    tm1638_model panel
    (
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  ),
        .key_mask     ( key_mask     ),
        .sio_data_in  ( sio_data_in  ),
        .value        ( shown        ),
        .dark         ( dark         ),
        .dots         ( dots         ),
        .leds         ( leds         ),
        .bad_seg      ( bad_seg      ),
        .oe_bad       ( oe_bad       ),
        .frames       ( frames       )
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    // inputs move 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++)
            next_cycle();
    endtask

    // digit d dark when it and all digits above are zero
    function automatic logic [7:0] dark_mask(input logic [31:0] v);
        logic [7:0] m;
        m = '0;
        for (int d = 1; d < 8; d++)
            m[d] = ((v >> (4 * d)) == 0);
        return m;
    endfunction

    //----------------------------------------
    // frame wait and per frame checks
    //----------------------------------------

    task automatic wait_frame();
        int start;
        int n;
        start = frames;
        n     = 0;
        while (frames == start && n < frame_timeout)
        begin
            next_cycle();
            n++;
        end
        if (frames == start)
            fail_run("timeout: no display frame completed on the panel");
        else
        begin
            assert (!bad_seg)
                else fail_run("panel received a segment code that is no hex digit");
            assert (!oe_bad)
                else fail_run("sio_data_oe had the wrong level while a byte was clocked");
            assert (leds == shown[7:0])
                else fail_run($sformatf("MISMATCH leds: got %h expected %h", leds, shown[7:0]));
            assert (dark == dark_mask(shown))
                else fail_run($sformatf("MISMATCH dark: got %h expected %h", dark,
                                        dark_mask(shown)));
        end
    endtask

    task automatic press_board_key(input int idx);
        key[idx] = 1'b0;
        wait_cycles(6);
        key[idx] = 1'b1;
    endtask

    // panel keys are read once per frame, hold over two
    task automatic press_panel_key(input int idx);
        key_mask[idx] = 1'b1;
        wait_frame();
        wait_frame();
        key_mask[idx] = 1'b0;
        wait_frame();
        wait_frame();
    endtask

    task automatic check_outcome(input outcome_t kind);
        logic [31:0] first;
        logic [31:0] last;
        wait_frame();
        wait_frame();
        first = shown;
        last  = shown;
        case (kind)
            exp_running:
            begin
                for (int i = 0; i < 3; i++)
                begin
                    assert (dots == 8'h01)
                        else fail_run($sformatf("MISMATCH dots: got %h expected 01", dots));
                    wait_frame();
                    assert (shown >= last)
                        else fail_run($sformatf("MISMATCH shown: got %h below %h", shown, last));
                    last = shown;
                end
                assert (last > first)
                    else fail_run("count did not advance while running");
            end
            exp_stopped:
            begin
                assert (dots == 8'h00)
                    else fail_run($sformatf("MISMATCH dots: got %h expected 00", dots));
                wait_frame();
                wait_frame();
                assert (shown == first)
                    else fail_run($sformatf("MISMATCH shown: got %h expected %h", shown, first));
            end
            default:
            begin
                // zero and cleared both mean 0 and stopped
                assert (shown == 32'h0)
                    else fail_run($sformatf("MISMATCH shown: got %h expected 0", shown));
                assert (dots == 8'h00)
                    else fail_run($sformatf("MISMATCH dots: got %h expected 00", dots));
            end
        endcase
    endtask

    initial
    begin
        rst      = 1'b1;
        key      = 2'b11;
        key_mask = '0;
        wait_cycles(10);
        // bus idles with strobe and clock high, dio released
        assert (sio_stb == 1'b1)
            else fail_run($sformatf("MISMATCH sio_stb: got %h expected 1", sio_stb));
        assert (sio_clk == 1'b1)
            else fail_run($sformatf("MISMATCH sio_clk: got %h expected 1", sio_clk));
        assert (sio_data_oe == 1'b0)
            else fail_run($sformatf("MISMATCH sio_data_oe: got %h expected 0", sio_data_oe));
        rst = 1'b0;
        for (int i = 0; i < 9; i++)
        begin
            case (steps[i].act)
                act_wait:
                    wait_cycles(tick_div * (2 + ($random(seed) & 3)));
                act_board_key:
                    press_board_key(steps[i].key_idx);
                default:
                    press_panel_key(steps[i].key_idx);
            endcase
            check_outcome(steps[i].outcome);
        end
        $display("sim passed");
        $finish;
    end

endmodule

//--- board_top.f
src/board_pkg.sv
src/tm1638_pkg.sv
src/display_if.sv
src/key_conditioner.sv
src/hex_counter.sv
src/tm1638_board_controller.sv
src/board_top.sv
tests/tm1638_model.sv
tests/board_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the board_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module board_top_tb -f board_top.f \
    -o board_top_sim > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat build.log
    echo "build failed with status $build_status"
    exit 1
fi

./obj_dir/board_top_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
exit 0
